// File: logic/hist_geom_pkg.sv
// default geometry of the photon arrival-time histograms
// the top level copies these into its module parameters
package hist_geom_pkg;

    // width of the time-bin index carried by each event
    localparam int DEF_BIN_W = 4;

    // width of the pixel index
    // pixels must fit in this width
    localparam int DEF_PIXEL_W = 2;

    // width of one bin counter
    // counters saturate at all ones
    localparam int DEF_COUNT_W = 8;

    // events taken per pixel before the sequencer moves on
    localparam int DEF_INPUTS_PER_PIXEL = 3;

    // pixels swept in one acquisition
    localparam int DEF_PIXELS = 4;

    // acquisitions that make up one frame
    // the banks swap after the last one
    localparam int DEF_ACQS = 2;

endpackage

// File: logic/hist_bus_pkg.sv
// wishbone widths and register map of the histogram readout
package hist_bus_pkg;

    // word address and data widths of the host bus
    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 32;

    // status word
    // bit 0 holds the filling bank, bits 15..8 the frame count
    localparam int STATUS_ADR       = 0;
    localparam int STATUS_BANK_BIT  = 0;
    localparam int STATUS_FRAME_LSB = 8;
    localparam int STATUS_FRAME_W   = 8;

    // first bin of the inactive bank
    // word BIN_BASE + pixel * bins + bin holds one counter
    // zero-extended to the data width, cleared when read
    localparam int BIN_BASE = 16;

endpackage

// File: logic/event_sequencer.sv
`timescale 1ns/1ns

module event_sequencer
    import hist_geom_pkg::*;
#(
    parameter int bin_w            = DEF_BIN_W,
    parameter int pixel_w          = DEF_PIXEL_W,
    parameter int inputs_per_pixel = DEF_INPUTS_PER_PIXEL,
    parameter int pixels           = DEF_PIXELS,
    parameter int acqs             = DEF_ACQS
) (
    input  logic               clk,
    input  logic               res,
    input  logic               ev_valid,
    input  logic [bin_w-1:0]   ev_bin,
    output logic               tag_valid,
    output logic [bin_w-1:0]   tag_bin,
    output logic [pixel_w-1:0] tag_pixel,
    output logic               tag_bank,
    output logic               his_num,
    output logic               frame_done
);

    // counter widths, at least one bit each
    localparam int in_w  = (inputs_per_pixel > 1) ? $clog2(inputs_per_pixel) : 1;
    localparam int acq_w = (acqs > 1) ? $clog2(acqs) : 1;

    logic [in_w-1:0]    in_cnt;
    logic [pixel_w-1:0] pix_cnt;
    logic [acq_w-1:0]   acq_cnt;
    logic               in_last;
    logic               pix_last;
    logic               acq_last;

    // last position of each counter
    assign in_last  = in_cnt == in_w'(inputs_per_pixel - 1);
    assign pix_last = pix_cnt == pixel_w'(pixels - 1);
    assign acq_last = acq_cnt == acq_w'(acqs - 1);

    // nested counters, advanced only by a valid event
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            in_cnt     <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            his_num    <= 1'b0;
            tag_valid  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            tag_valid  <= ev_valid;
            // final event of the frame, same edge as the bank swap
            frame_done <= ev_valid && in_last && pix_last && acq_last;
            if (ev_valid) begin
                if (!in_last) begin
                    in_cnt <= in_cnt + 1'b1;
                end else begin
                    in_cnt <= '0;
                    if (!pix_last) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end else begin
                        pix_cnt <= '0;
                        if (!acq_last) begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end else begin
                            acq_cnt <= '0;
                            his_num <= ~his_num;
                        end
                    end
                end
            end
        end
    end

    // tag keeps the bank that was filling when the event came in
    always_ff @(posedge clk) begin
        if (ev_valid) begin
            tag_bin   <= ev_bin;
            tag_pixel <= pix_cnt;
            tag_bank  <= his_num;
        end
    end

    // counters never leave their range
    a_cnt_range: assert property (@(posedge clk) disable iff (!res)
        (in_cnt < inputs_per_pixel) && (pix_cnt < pixels) && (acq_cnt < acqs));

endmodule

// File: logic/bin_accumulator.sv
`timescale 1ns/1ns

module bin_accumulator
    import hist_geom_pkg::*;
#(
    parameter int bin_w   = DEF_BIN_W,
    parameter int pixel_w = DEF_PIXEL_W,
    parameter int count_w = DEF_COUNT_W,
    parameter int pixels  = DEF_PIXELS
) (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       tag_valid,
    input  logic [bin_w-1:0]           tag_bin,
    input  logic [pixel_w-1:0]         tag_pixel,
    input  logic                       tag_bank,
    input  logic                       his_num,
    input  logic                       rd_en,
    input  logic [pixel_w+bin_w-1:0]   rd_addr,
    output logic [count_w-1:0]         rd_data
);

    // counters in one bank
    localparam int depth  = pixels << bin_w;
    localparam int addr_w = pixel_w + bin_w;
    // index over both banks
    localparam int idx_w  = $clog2(2 * depth);

    localparam logic [count_w-1:0] cnt_max = '1;

    // bank 0 in the lower half, bank 1 in the upper half
    // zero at start of simulation
    logic [count_w-1:0] mem [2*depth] = '{default: '0};

    logic [addr_w-1:0]  tag_addr;
    logic [idx_w-1:0]   tag_idx;
    logic [idx_w-1:0]   rd_idx;

    // stage 1 holds the tag and the counter read for it
    logic               s1_valid;
    logic [idx_w-1:0]   s1_idx;
    logic               s1_bank;
    logic [count_w-1:0] s1_cnt;

    // stage 2 write value
    logic [count_w-1:0] wr_val;
    logic               fwd;

    function automatic logic [idx_w-1:0] bank_index(input logic bank,
                                                   input logic [addr_w-1:0] addr);
        logic [idx_w-1:0] base;
        base = bank ? idx_w'(depth) : '0;
        return base + idx_w'(addr);
    endfunction

    // pixel selects a block of bins
    assign tag_addr = {tag_pixel, tag_bin};
    assign tag_idx  = bank_index(tag_bank, tag_addr);

    // host always reads the bank not being filled
    assign rd_idx = bank_index(~his_num, rd_addr);

    // saturating increment
    assign wr_val = (s1_cnt == cnt_max) ? s1_cnt : s1_cnt + 1'b1;

    // next event hits the counter being written right now
    assign fwd = s1_valid && (s1_idx == tag_idx);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= tag_valid;
        end
    end

    always_ff @(posedge clk) begin
        // stage 2 write back
        if (s1_valid) begin
            mem[s1_idx] <= wr_val;
        end
        // stage 1 read, memory is still stale on a back-to-back hit
        if (tag_valid) begin
            s1_idx  <= tag_idx;
            s1_bank <= tag_bank;
            s1_cnt  <= fwd ? wr_val : mem[tag_idx];
        end
        // host read clears the counter it returns
        if (rd_en) begin
            rd_data     <= mem[rd_idx];
            mem[rd_idx] <= '0;
        end
    end

    // event write and host clear never share a bank
    a_bank_split: assert property (@(posedge clk) disable iff (!res)
        !(s1_valid && rd_en && (s1_bank == ~his_num)));

    // host address inside one bank
    a_rd_range: assert property (@(posedge clk) disable iff (!res)
        rd_en |-> (int'(rd_addr) < depth));

endmodule

// File: logic/hist_readout.sv
`timescale 1ns/1ns

module hist_readout
    import hist_geom_pkg::*;
    import hist_bus_pkg::*;
#(
    parameter int bin_w   = DEF_BIN_W,
    parameter int pixel_w = DEF_PIXEL_W,
    parameter int count_w = DEF_COUNT_W,
    parameter int pixels  = DEF_PIXELS
) (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [WB_ADR_W-1:0]      wb_adr,
    input  logic [WB_DAT_W-1:0]      wb_dat_w,
    output logic [WB_DAT_W-1:0]      wb_dat_r,
    output logic                     wb_ack,
    input  logic                     his_num,
    input  logic                     frame_done,
    output logic                     rd_en,
    output logic [pixel_w+bin_w-1:0] rd_addr,
    input  logic [count_w-1:0]       rd_data
);

    localparam int depth  = pixels << bin_w;
    localparam int addr_w = pixel_w + bin_w;

    // idle, read issued, data captured with ack
    localparam logic [1:0] P_IDLE = 2'd0;
    localparam logic [1:0] P_READ = 2'd1;
    localparam logic [1:0] P_CAPT = 2'd2;

    logic [1:0]                phase;
    logic                      start;
    logic                      sel_status;
    logic                      sel_bin;
    logic                      req_status;
    logic                      req_bin;
    logic [WB_ADR_W-1:0]       bin_off;
    logic [STATUS_FRAME_W-1:0] frame_cnt;
    logic [WB_DAT_W-1:0]       status_word;

    // new transfer, ack still high means the last one is ending
    assign start = (phase == P_IDLE) && wb_cyc && wb_stb && !wb_ack;

    // address decode
    assign sel_status = int'(wb_adr) == STATUS_ADR;
    assign sel_bin    = (int'(wb_adr) >= BIN_BASE) && (int'(wb_adr) < BIN_BASE + depth);
    assign bin_off    = wb_adr - WB_ADR_W'(BIN_BASE);

    always_comb begin
        status_word = '0;
        status_word[STATUS_BANK_BIT] = his_num;
        status_word[STATUS_FRAME_LSB +: STATUS_FRAME_W] = frame_cnt;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase      <= P_IDLE;
            rd_en      <= 1'b0;
            wb_ack     <= 1'b0;
            req_status <= 1'b0;
            req_bin    <= 1'b0;
            frame_cnt  <= '0;
        end else begin
            rd_en  <= 1'b0;
            wb_ack <= 1'b0;
            if (frame_done) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            case (phase)
                P_IDLE: begin
                    if (start) begin
                        phase      <= P_READ;
                        // writes fall through with no effect
                        req_status <= sel_status && !wb_we;
                        req_bin    <= sel_bin && !wb_we;
                        rd_en      <= sel_bin && !wb_we;
                    end
                end
                P_READ: begin
                    phase <= P_CAPT;
                end
                P_CAPT: begin
                    phase  <= P_IDLE;
                    wb_ack <= 1'b1;
                end
                default: begin
                    phase <= P_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rd_addr <= addr_w'(bin_off);
        end
        // unmapped and write cycles return zero
        if (phase == P_CAPT) begin
            if (req_bin) begin
                wb_dat_r <= WB_DAT_W'(rd_data);
            end else if (req_status) begin
                wb_dat_r <= status_word;
            end else begin
                wb_dat_r <= '0;
            end
        end
    end

    // master holds stb until it sees ack
    a_ack_stb: assert property (@(posedge clk) disable iff (!res)
        wb_ack |-> wb_stb);

    a_ack_once: assert property (@(posedge clk) disable iff (!res)
        wb_ack |=> !wb_ack);

    // write data is defined while a write is on the bus
    a_wdat_known: assert property (@(posedge clk) disable iff (!res)
        (wb_cyc && wb_stb && wb_we) |-> !$isunknown(wb_dat_w));

endmodule

// File: logic/hist_builder_top.sv
`timescale 1ns/1ns

module hist_builder_top
    import hist_geom_pkg::*;
    import hist_bus_pkg::*;
#(
    parameter int bin_w            = DEF_BIN_W,
    parameter int pixel_w          = DEF_PIXEL_W,
    parameter int count_w          = DEF_COUNT_W,
    parameter int inputs_per_pixel = DEF_INPUTS_PER_PIXEL,
    parameter int pixels           = DEF_PIXELS,
    parameter int acqs             = DEF_ACQS
) (
    input  logic                clk,
    input  logic                res,
    input  logic                ev_valid,
    input  logic [bin_w-1:0]    ev_bin,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [WB_DAT_W-1:0] wb_dat_w,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack,
    output logic                his_num
);

    // tagged events into the accumulator
    logic                     tag_valid;
    logic [bin_w-1:0]         tag_bin;
    logic [pixel_w-1:0]       tag_pixel;
    logic                     tag_bank;
    logic                     frame_done;
    // host port between readout and accumulator
    logic                     rd_en;
    logic [pixel_w+bin_w-1:0] rd_addr;
    logic [count_w-1:0]       rd_data;

    event_sequencer #(
        .bin_w(bin_w), .pixel_w(pixel_w), .inputs_per_pixel(inputs_per_pixel),
        .pixels(pixels), .acqs(acqs)
    ) u_seq (
        .clk(clk), .res(res), .ev_valid(ev_valid), .ev_bin(ev_bin),
        .tag_valid(tag_valid), .tag_bin(tag_bin), .tag_pixel(tag_pixel),
        .tag_bank(tag_bank), .his_num(his_num), .frame_done(frame_done)
    );

    bin_accumulator #(
        .bin_w(bin_w), .pixel_w(pixel_w), .count_w(count_w), .pixels(pixels)
    ) u_acc (
        .clk(clk), .res(res), .tag_valid(tag_valid), .tag_bin(tag_bin),
        .tag_pixel(tag_pixel), .tag_bank(tag_bank), .his_num(his_num),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    hist_readout #(
        .bin_w(bin_w), .pixel_w(pixel_w), .count_w(count_w), .pixels(pixels)
    ) u_rdo (
        .clk(clk), .res(res), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .his_num(his_num), .frame_done(frame_done),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

// File: bench/hist_builder_tb.sv
`timescale 1ns/1ns

module hist_builder_tb
    import hist_geom_pkg::*;
    import hist_bus_pkg::*;
();

    localparam int BINS    = 1 << DEF_BIN_W;
    localparam int DEPTH   = DEF_PIXELS * BINS;
    localparam int CNT_MAX = (1 << DEF_COUNT_W) - 1;
    localparam int FRAME   = DEF_INPUTS_PER_PIXEL * DEF_PIXELS * DEF_ACQS;
    // 6 hits per pixel and frame on one bin
    // 43 frames per bank pass the maximum
    localparam int SAT_FRAMES = 86;
    // events sent while the host drains
    localparam int PART = 10;
    // frames of tests 2, 3, 4 and 5
    localparam int N_EVENTS = FRAME * (2 + SAT_FRAMES + 4);
    // transfers of tests 1 to 6 summed
    localparam int N_READS = 8 * DEPTH + 14;
    localparam int WATCHDOG_NS = N_EVENTS * 20 + N_READS * 60 + 5000;

    logic                 clk;
    logic                 res;
    logic                 ev_valid;
    logic [DEF_BIN_W-1:0] ev_bin;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADR_W-1:0]  wb_adr;
    logic [WB_DAT_W-1:0]  wb_dat_w;
    logic [WB_DAT_W-1:0]  wb_dat_r;
    logic                 wb_ack;
    logic                 his_num;

    // expected read data of the transfer on the bus
    logic [WB_DAT_W-1:0]  exp_data;

    // reference model with two banks and the sequencing counters
    int mdl [2][DEPTH];
    int m_in;
    int m_pix;
    int m_acq;
    int m_bank;
    int m_frames;

    int err_cnt;
    int chk_cnt;
    int ack_cnt;
    int xfer_cnt;
    int errs_before;
    // bin hit in the first frame, read a second time
    int reread_idx;

    hist_builder_top #(
        .bin_w(DEF_BIN_W), .pixel_w(DEF_PIXEL_W), .count_w(DEF_COUNT_W),
        .inputs_per_pixel(DEF_INPUTS_PER_PIXEL), .pixels(DEF_PIXELS), .acqs(DEF_ACQS)
    ) UUT (
        .clk(clk), .res(res), .ev_valid(ev_valid), .ev_bin(ev_bin),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .his_num(his_num)
    );

    always #5 clk = ~clk;

    // acks counted on the falling edge
    // one per transfer expected
    always @(negedge clk) begin
        if (wb_ack) begin
            ack_cnt++;
        end
    end

    // every read ack carries the value the model predicts
    a_rd_data: assert property (@(posedge clk) disable iff (!res)
        (wb_ack && !wb_we) |-> (wb_dat_r == exp_data))
    else begin
        $display("FAILED wb_dat_r at wb_adr %h: got %h expected %h",
                 wb_adr, wb_dat_r, exp_data);
        err_cnt++;
    end

    // model of the sequencer and the saturating counter
    task automatic model_event(input int bin);
        int idx;
        idx = m_pix * BINS + bin;
        if (mdl[m_bank][idx] < CNT_MAX) begin
            mdl[m_bank][idx]++;
        end
        m_in++;
        if (m_in == DEF_INPUTS_PER_PIXEL) begin
            m_in = 0;
            m_pix++;
            if (m_pix == DEF_PIXELS) begin
                m_pix = 0;
                m_acq++;
                if (m_acq == DEF_ACQS) begin
                    m_acq = 0;
                    m_bank = 1 - m_bank;
                    m_frames++;
                end
            end
        end
    endtask

    // n events on a fixed bin when bin >= 0
    // random idle gaps when gaps is set
    task automatic send_events(input int n, input int bin, input bit gaps);
        int b;
        int gap;
        for (int i = 0; i < n; i++) begin
            b   = (bin < 0) ? int'($urandom_range(0, BINS - 1)) : bin;
            gap = gaps ? int'($urandom_range(0, 2)) : 0;
            @(negedge clk);
            ev_valid = 1'b1;
            ev_bin   = DEF_BIN_W'(b);
            model_event(b);
            repeat (gap) begin
                @(negedge clk);
                ev_valid = 1'b0;
            end
        end
        @(negedge clk);
        ev_valid = 1'b0;
    endtask

    // classic cycle with stb held through the edge that samples ack
    task automatic wb_xfer(input int adr, input logic we, input logic [WB_DAT_W-1:0] wdat,
                           input logic [WB_DAT_W-1:0] exp);
        exp_data = exp;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = WB_ADR_W'(adr);
        wb_dat_w = wdat;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        xfer_cnt++;
        if (!we) begin
            chk_cnt++;
        end
    endtask

    // one bin of the inactive bank
    // cleared in the model once read
    task automatic read_bin(input int pix, input int bin);
        int idx;
        int bank;
        idx  = pix * BINS + bin;
        bank = 1 - m_bank;
        wb_xfer(BIN_BASE + idx, 1'b0, '0, WB_DAT_W'(mdl[bank][idx]));
        mdl[bank][idx] = 0;
    endtask

    task automatic read_status();
        logic [WB_DAT_W-1:0] exp;
        exp = '0;
        exp[STATUS_BANK_BIT] = m_bank[0];
        exp[STATUS_FRAME_LSB +: STATUS_FRAME_W] = m_frames[STATUS_FRAME_W-1:0];
        wb_xfer(STATUS_ADR, 1'b0, '0, exp);
    endtask

    task automatic drain_bank();
        for (int p = 0; p < DEF_PIXELS; p++) begin
            for (int b = 0; b < BINS; b++) begin
                read_bin(p, b);
            end
        end
    endtask

    // memory and frame_done settle before a readout
    task automatic settle();
        repeat (4) @(negedge clk);
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        if (err_cnt == errs) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, err_cnt - errs);
        end
    endtask

    // hard limit on run time
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(9));
        clk      = 1'b0;
        res      = 1'b0;
        ev_valid = 1'b0;
        ev_bin   = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        exp_data = '0;
        m_in     = 0;
        m_pix    = 0;
        m_acq    = 0;
        m_bank   = 0;
        m_frames = 0;
        err_cnt  = 0;
        chk_cnt  = 0;
        ack_cnt  = 0;
        xfer_cnt = 0;
        reread_idx = 0;
        for (int i = 0; i < DEPTH; i++) begin
            mdl[0][i] = 0;
            mdl[1][i] = 0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
        settle();

        errs_before = err_cnt;
        read_status();
        drain_bank();
        report_test(1, "reset state", errs_before);

        errs_before = err_cnt;
        send_events(FRAME, -1, 1'b1);
        settle();
        chk_cnt++;
        assert (his_num == m_bank[0])
        else begin
            $display("FAILED his_num: got %h expected %h", his_num, m_bank[0]);
            err_cnt++;
        end
        read_status();
        // pick a bin the frame actually hit
        for (int i = 0; i < DEPTH; i++) begin
            if (mdl[1 - m_bank][i] != 0) begin
                reread_idx = i;
            end
        end
        drain_bank();
        // second read of that bin finds it cleared
        read_bin(reread_idx / BINS, reread_idx % BINS);
        report_test(2, "frame readout and clear-on-read", errs_before);

        errs_before = err_cnt;
        send_events(FRAME, 7, 1'b0);
        settle();
        drain_bank();
        report_test(3, "back-to-back forwarding", errs_before);

        errs_before = err_cnt;
        send_events(FRAME * SAT_FRAMES, 5, 1'b0);
        settle();
        drain_bank();
        report_test(4, "counter saturation", errs_before);

        errs_before = err_cnt;
        for (int f = 0; f < 3; f++) begin
            send_events((f == 0) ? FRAME : FRAME - PART, -1, 1'b1);
            settle();
            read_status();
            // drain while the other bank keeps filling
            fork
                drain_bank();
                send_events(PART, -1, 1'b1);
            join
        end
        send_events(FRAME - PART, -1, 1'b1);
        settle();
        drain_bank();
        report_test(5, "bank alternation", errs_before);

        errs_before = err_cnt;
        wb_xfer(1, 1'b0, '0, '0);
        wb_xfer(BIN_BASE - 1, 1'b0, '0, '0);
        wb_xfer(BIN_BASE + DEPTH, 1'b0, '0, '0);
        wb_xfer((1 << WB_ADR_W) - 1, 1'b0, '0, '0);
        wb_xfer(STATUS_ADR, 1'b1, 32'hffff_ffff, '0);
        wb_xfer(BIN_BASE + 5, 1'b1, 32'h0000_0012, '0);
        read_status();
        read_bin(0, 5);
        chk_cnt++;
        assert (ack_cnt == xfer_cnt)
        else begin
            $display("FAILED wb_ack count: got %h expected %h", ack_cnt, xfer_cnt);
            err_cnt++;
        end
        report_test(6, "unmapped, writes and ack count", errs_before);

        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src.f
logic/hist_geom_pkg.sv
logic/hist_bus_pkg.sv
logic/event_sequencer.sv
logic/bin_accumulator.sv
logic/hist_readout.sv
logic/hist_builder_top.sv
bench/hist_builder_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the histogram builder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module hist_builder_tb -f src.f -o hist_sim

out="$(./obj_dir/hist_sim)"
echo "$out"

if grep -qx "Simulation passed" <<< "$out"; then
    exit 0
fi
exit 1
